// File: source/cpu_types_pkg.sv
/*
 * shared types for the single-cycle MIPS subset core
 * width localparams, opcode / funct / alu operation enums,
 * decoded instruction fields and the control word
 */
`default_nettype none

package cpu_types_pkg;

   localparam int word_w     = 32;
   localparam int reg_addr_w = 5;
   localparam int imm_w      = 16;
   localparam int op_w       = 6;
   localparam int funct_w    = 6;
   localparam int num_regs   = 2 ** reg_addr_w;

   // instr[31:26]
   typedef enum logic [op_w-1:0] {
      rtype = 6'b000000,
      beq   = 6'b000100,
      bne   = 6'b000101,
      andi  = 6'b001100,
      ori   = 6'b001101,
      xori  = 6'b001110,
      lui   = 6'b001111,
      lw    = 6'b100011,
      sw    = 6'b101011,
      halt  = 6'b111111
   } opcode_t;

   // instr[5:0] when opcode is rtype
   typedef enum logic [funct_w-1:0] {
      fn_sll  = 6'b000000,
      fn_srl  = 6'b000010,
      fn_add  = 6'b100000,
      fn_addu = 6'b100001,
      fn_sub  = 6'b100010,
      fn_subu = 6'b100011,
      fn_and  = 6'b100100,
      fn_or   = 6'b100101,
      fn_xor  = 6'b100110,
      fn_nor  = 6'b100111,
      fn_slt  = 6'b101010,
      fn_sltu = 6'b101011
   } funct_t;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_nor,
      alu_sll,
      alu_srl,
      alu_slt,
      alu_sltu
   } alu_op_t;

   typedef struct packed {
      logic [reg_addr_w-1:0] rs;
      logic [reg_addr_w-1:0] rt;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] shamt;
      logic [imm_w-1:0]      imm16;
   } instr_fields_t;

   typedef struct packed {
      logic reg_dst;     // 1 = rd, 0 = rt
      logic ext_op;      // 1 = sign extend
      logic alu_src;     // 1 = immediate operand
      logic mem_wr;
      logic mem_rd;
      logic mem_to_reg;
      logic lui_sel;
      logic reg_wr;
      logic shift_sel;   // shamt drives the shifter
      logic halt;
   } ctrl_t;

endpackage

`default_nettype wire

// File: source/alu.sv
/*
 * combinational alu
 * arithmetic, logic, shifts, signed and unsigned compare, zero flag
 */
`default_nettype none

module alu (
   input  cpu_types_pkg::alu_op_t                op,
   input  logic [cpu_types_pkg::word_w-1:0]     a,
   input  logic [cpu_types_pkg::word_w-1:0]     b,
   input  logic [cpu_types_pkg::reg_addr_w-1:0] shamt,
   output logic [cpu_types_pkg::word_w-1:0]     result,
   output logic                                 zero
);

   logic lt_signed;
   logic lt_unsigned;

   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      case (op)
         cpu_types_pkg::alu_add:  result = a + b;
         cpu_types_pkg::alu_sub:  result = a - b;
         cpu_types_pkg::alu_and:  result = a & b;
         cpu_types_pkg::alu_or:   result = a | b;
         cpu_types_pkg::alu_xor:  result = a ^ b;
         cpu_types_pkg::alu_nor:  result = ~(a | b);
         cpu_types_pkg::alu_sll:  result = b << shamt;   // shifts act on rt
         cpu_types_pkg::alu_srl:  result = b >> shamt;   // logical, zero fill
         cpu_types_pkg::alu_slt: begin
            result = {{(cpu_types_pkg::word_w-1){1'b0}}, lt_signed};
         end
         cpu_types_pkg::alu_sltu: begin
            result = {{(cpu_types_pkg::word_w-1){1'b0}}, lt_unsigned};
         end
         default: result = '0;
      endcase
   end

   // used by beq / bne after a subtract
   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/register_file.sv
/*
 * 32 x 32 register file
 * two combinational read ports, one write port, r0 reads zero
 */
`default_nettype none

module register_file (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 wen,
   input  logic [cpu_types_pkg::reg_addr_w-1:0] waddr,
   input  logic [cpu_types_pkg::word_w-1:0]     wdata,
   input  logic [cpu_types_pkg::reg_addr_w-1:0] raddr1,
   input  logic [cpu_types_pkg::reg_addr_w-1:0] raddr2,
   output logic [cpu_types_pkg::word_w-1:0]     rdata1,
   output logic [cpu_types_pkg::word_w-1:0]     rdata2
);

   logic [cpu_types_pkg::word_w-1:0] regs [cpu_types_pkg::num_regs];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < cpu_types_pkg::num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && (waddr != '0)) begin   // r0 writes dropped
         regs[waddr] <= wdata;
      end
   end

   // old value visible until the writing edge
   assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
   assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: source/control_unit.sv
/*
 * instruction decode for the single-cycle core
 * field split, control word, alu operation select, branch decision
 */
`default_nettype none

module control_unit (
   input  logic [cpu_types_pkg::word_w-1:0] instr,
   input  logic                             zero,
   output cpu_types_pkg::instr_fields_t     fields,
   output cpu_types_pkg::ctrl_t             ctrl,
   output cpu_types_pkg::alu_op_t           alu_op,
   output logic                             pc_src
);

   cpu_types_pkg::opcode_t op;
   cpu_types_pkg::funct_t  funct;
   logic                   is_shift;

   assign op           = cpu_types_pkg::opcode_t'(instr[31:26]);
   assign funct        = cpu_types_pkg::funct_t'(instr[5:0]);
   assign fields.rs    = instr[25:21];
   assign fields.rt    = instr[20:16];
   assign fields.rd    = instr[15:11];
   assign fields.shamt = instr[10:6];
   assign fields.imm16 = instr[15:0];

   assign is_shift = (funct == cpu_types_pkg::fn_sll) || (funct == cpu_types_pkg::fn_srl);

   always_comb begin
      ctrl        = '0;
      ctrl.ext_op = 1'b1;   // sign extend unless logical immediate
      case (op)
         cpu_types_pkg::rtype: begin
            ctrl.reg_dst   = 1'b1;
            ctrl.reg_wr    = 1'b1;
            ctrl.shift_sel = is_shift;
         end
         cpu_types_pkg::ori,
         cpu_types_pkg::andi,
         cpu_types_pkg::xori: begin
            ctrl.ext_op  = 1'b0;
            ctrl.alu_src = 1'b1;
            ctrl.reg_wr  = 1'b1;
         end
         cpu_types_pkg::lui: begin
            ctrl.lui_sel = 1'b1;
            ctrl.reg_wr  = 1'b1;
         end
         cpu_types_pkg::lw: begin
            ctrl.alu_src    = 1'b1;
            ctrl.mem_rd     = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.reg_wr     = 1'b1;
         end
         cpu_types_pkg::sw: begin
            ctrl.alu_src = 1'b1;
            ctrl.mem_wr  = 1'b1;
         end
         cpu_types_pkg::halt: ctrl.halt = 1'b1;
         default: ;          // unknown opcode behaves as nop
      endcase
   end

   always_comb begin
      if (op == cpu_types_pkg::rtype) begin
         case (funct)
            cpu_types_pkg::fn_sub,
            cpu_types_pkg::fn_subu: alu_op = cpu_types_pkg::alu_sub;
            cpu_types_pkg::fn_and:  alu_op = cpu_types_pkg::alu_and;
            cpu_types_pkg::fn_or:   alu_op = cpu_types_pkg::alu_or;
            cpu_types_pkg::fn_xor:  alu_op = cpu_types_pkg::alu_xor;
            cpu_types_pkg::fn_nor:  alu_op = cpu_types_pkg::alu_nor;
            cpu_types_pkg::fn_sll:  alu_op = cpu_types_pkg::alu_sll;
            cpu_types_pkg::fn_srl:  alu_op = cpu_types_pkg::alu_srl;
            cpu_types_pkg::fn_slt:  alu_op = cpu_types_pkg::alu_slt;
            cpu_types_pkg::fn_sltu: alu_op = cpu_types_pkg::alu_sltu;
            default:                alu_op = cpu_types_pkg::alu_add;  // add, addu
         endcase
      end else begin
         case (op)
            cpu_types_pkg::ori:  alu_op = cpu_types_pkg::alu_or;
            cpu_types_pkg::andi: alu_op = cpu_types_pkg::alu_and;
            cpu_types_pkg::xori: alu_op = cpu_types_pkg::alu_xor;
            cpu_types_pkg::beq,
            cpu_types_pkg::bne:  alu_op = cpu_types_pkg::alu_sub;  // compare rs, rt
            default:             alu_op = cpu_types_pkg::alu_add;  // lw / sw address
         endcase
      end
   end

   // branch decision lives only here
   assign pc_src = ((op == cpu_types_pkg::beq) &&  zero) ||
                   ((op == cpu_types_pkg::bne) && !zero);

endmodule

`default_nettype wire

// File: source/single_cycle_cpu.sv
/*
 * single-cycle MIPS subset core
 * pc and halt flag, immediate extension, operand and write-back muxes,
 * instruction and data memory ports
 */
`default_nettype none

module single_cycle_cpu (
   input  logic                             clk,
   input  logic                             rst,
   output logic [cpu_types_pkg::word_w-1:0] imem_addr,
   input  logic [cpu_types_pkg::word_w-1:0] instr,
   output logic [cpu_types_pkg::word_w-1:0] dmem_addr,
   output logic [cpu_types_pkg::word_w-1:0] dmem_wdata,
   output logic                             dmem_wen,
   output logic                             dmem_ren,
   input  logic [cpu_types_pkg::word_w-1:0] dmem_rdata,
   output logic                             halted
);

   localparam int ext_w = cpu_types_pkg::word_w - cpu_types_pkg::imm_w;

   logic [cpu_types_pkg::word_w-1:0]     pc;
   logic [cpu_types_pkg::word_w-1:0]     pc_plus4;
   logic [cpu_types_pkg::word_w-1:0]     br_target;
   cpu_types_pkg::instr_fields_t         fields;
   cpu_types_pkg::ctrl_t                 ctrl;
   cpu_types_pkg::alu_op_t               alu_op;
   logic                                 pc_src;
   logic                                 zero;
   logic [cpu_types_pkg::word_w-1:0]     rdata1;
   logic [cpu_types_pkg::word_w-1:0]     rdata2;
   logic [cpu_types_pkg::word_w-1:0]     imm_ext;
   logic [cpu_types_pkg::word_w-1:0]     alu_b;
   logic [cpu_types_pkg::reg_addr_w-1:0] alu_shamt;
   logic [cpu_types_pkg::word_w-1:0]     alu_result;
   logic [cpu_types_pkg::word_w-1:0]     wb_data;
   logic [cpu_types_pkg::reg_addr_w-1:0] wb_addr;
   logic                                 active;

   control_unit u_ctrl (
      .instr  (instr),
      .zero   (zero),
      .fields (fields),
      .ctrl   (ctrl),
      .alu_op (alu_op),
      .pc_src (pc_src)
   );

   register_file u_regs (
      .clk    (clk),
      .rst    (rst),
      .wen    (ctrl.reg_wr && active),
      .waddr  (wb_addr),
      .wdata  (wb_data),
      .raddr1 (fields.rs),
      .raddr2 (fields.rt),
      .rdata1 (rdata1),
      .rdata2 (rdata2)
   );

   alu u_alu (
      .op     (alu_op),
      .a      (rdata1),
      .b      (alu_b),
      .shamt  (alu_shamt),
      .result (alu_result),
      .zero   (zero)
   );

   // nothing commits in reset or once halted
   assign active = !rst && !halted;

   assign imm_ext = ctrl.ext_op ? {{ext_w{fields.imm16[cpu_types_pkg::imm_w-1]}}, fields.imm16}
                                : {{ext_w{1'b0}}, fields.imm16};

   assign alu_b     = ctrl.alu_src ? imm_ext : rdata2;
   assign alu_shamt = ctrl.shift_sel ? fields.shamt : '0;

   assign wb_addr = ctrl.reg_dst ? fields.rd : fields.rt;

   always_comb begin
      if (ctrl.mem_to_reg) begin
         wb_data = dmem_rdata;
      end else if (ctrl.lui_sel) begin
         wb_data = {fields.imm16, {ext_w{1'b0}}};   // imm in upper half
      end else begin
         wb_data = alu_result;
      end
   end

   // word addressed data port, address straight from the adder
   assign dmem_addr  = alu_result;
   assign dmem_wdata = rdata2;
   assign dmem_wen   = ctrl.mem_wr && active;
   assign dmem_ren   = ctrl.mem_rd && active;

   assign imem_addr = pc;
   assign pc_plus4  = pc + 32'd4;
   assign br_target = pc_plus4 + {imm_ext[cpu_types_pkg::word_w-3:0], 2'b00};

   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (!halted) begin
         if (ctrl.halt) begin
            halted <= 1'b1;    // pc stays on the halt word
         end else begin
            pc <= pc_src ? br_target : pc_plus4;
         end
      end
   end

endmodule

`default_nettype wire

// File: verif/cpu_model.svh
/*
 * reference model of the core state
 * pc, registers, data memory, expected data port for each step
 */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [31:0] m_pc;
logic [31:0] m_regs [32];
logic [31:0] m_mem [64];
logic        m_halted;
logic        exp_wen;
logic        exp_ren;
logic [31:0] exp_addr;
logic [31:0] exp_wdata;

task automatic model_reset();
   m_pc     = '0;
   m_halted = 1'b0;
   for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
   end
   for (int i = 0; i < 64; i++) begin
      m_mem[i] = '0;
   end
endtask

// commit one instruction word
task automatic model_step(input logic [31:0] iw);
   cpu_types_pkg::opcode_t op;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] sx;
   logic [31:0] zx;
   logic [31:0] res;
   logic [31:0] nxt;
   logic [4:0]  dst;
   logic        wr;
   op      = cpu_types_pkg::opcode_t'(iw[31:26]);
   a       = m_regs[iw[25:21]];
   b       = m_regs[iw[20:16]];
   sx      = {{16{iw[15]}}, iw[15:0]};
   zx      = {16'h0, iw[15:0]};
   nxt     = m_pc + 4;
   dst     = iw[20:16];
   wr      = 1'b1;
   res     = '0;
   exp_wen = 1'b0;
   exp_ren = 1'b0;
   case (op)
      cpu_types_pkg::rtype: begin
         dst = iw[15:11];
         case (cpu_types_pkg::funct_t'(iw[5:0]))
            cpu_types_pkg::fn_add, cpu_types_pkg::fn_addu: res = a + b;
            cpu_types_pkg::fn_sub, cpu_types_pkg::fn_subu: res = a - b;
            cpu_types_pkg::fn_and:  res = a & b;
            cpu_types_pkg::fn_or:   res = a | b;
            cpu_types_pkg::fn_xor:  res = a ^ b;
            cpu_types_pkg::fn_nor:  res = ~(a | b);
            cpu_types_pkg::fn_sll:  res = b << iw[10:6];
            cpu_types_pkg::fn_srl:  res = b >> iw[10:6];
            cpu_types_pkg::fn_slt:  res = {31'd0, $signed(a) < $signed(b)};
            cpu_types_pkg::fn_sltu: res = {31'd0, a < b};
            default:                wr = 1'b0;
         endcase
      end
      cpu_types_pkg::ori:  res = a | zx;   // logical immediates zero extend
      cpu_types_pkg::andi: res = a & zx;
      cpu_types_pkg::xori: res = a ^ zx;
      cpu_types_pkg::lui:  res = {iw[15:0], 16'h0};
      cpu_types_pkg::lw: begin
         exp_ren  = 1'b1;
         exp_addr = a + sx;
         res      = m_mem[exp_addr[7:2]];
      end
      cpu_types_pkg::sw: begin
         wr        = 1'b0;
         exp_wen   = 1'b1;
         exp_addr  = a + sx;
         exp_wdata = b;
         m_mem[exp_addr[7:2]] = b;
      end
      cpu_types_pkg::beq, cpu_types_pkg::bne: begin
         wr = 1'b0;
         if ((a == b) == (op == cpu_types_pkg::beq)) nxt = nxt + (sx << 2);
      end
      cpu_types_pkg::halt: begin
         wr       = 1'b0;
         m_halted = 1'b1;
         nxt      = m_pc;   // pc parks on the halt word
      end
      default: wr = 1'b0;
   endcase
   if (wr && dst != 5'd0) m_regs[dst] = res;
   m_pc = nxt;
endtask

`endif

// File: verif/cpu_tb.sv
/*
 * testbench for the single-cycle core
 * clock and reset, lfsr program generator, memory models,
 * per-cycle checks against the reference model, closing report
 */
`default_nettype none

module cpu_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int timeout_cycles = 2000;
   localparam int rand_words     = 48;   // then sw of r1..r15, then halt

   logic        clk;
   logic        rst;
   logic [31:0] imem_addr;
   logic [31:0] instr;
   logic [31:0] dmem_addr;
   logic [31:0] dmem_wdata;
   logic [31:0] dmem_rdata;
   logic        dmem_wen;
   logic        dmem_ren;
   logic        halted;
   logic [31:0] imem [64];
   logic [31:0] dmem [64];
   logic [15:0] lfsr;
   int          errors;
   int          cycles;
   logic [31:0] hold_addr;
   logic [31:0] saved_word;

   `include "cpu_model.svh"

   single_cycle_cpu uut (
      .clk        (clk),
      .rst        (rst),
      .imem_addr  (imem_addr),
      .instr      (instr),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_wen   (dmem_wen),
      .dmem_ren   (dmem_ren),
      .dmem_rdata (dmem_rdata),
      .halted     (halted)
   );

   always #20 clk = ~clk;

   assign instr      = imem[imem_addr[7:2]];   // combinational fetch
   assign dmem_rdata = dmem[dmem_addr[7:2]];

   always @(posedge clk) begin
      if (dmem_wen) dmem[dmem_addr[7:2]] <= dmem_wdata;
   end

   // taps 16 14 13 11, one step per bit
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else begin
         errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic build_program();
      cpu_types_pkg::funct_t  fns [12];
      cpu_types_pkg::funct_t  fn;
      cpu_types_pkg::opcode_t op;
      logic [31:0] kind;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [4:0]  sh;
      logic [15:0] imm;
      int          off;
      fns = '{cpu_types_pkg::fn_add, cpu_types_pkg::fn_addu, cpu_types_pkg::fn_sub,
              cpu_types_pkg::fn_subu, cpu_types_pkg::fn_and, cpu_types_pkg::fn_or,
              cpu_types_pkg::fn_xor, cpu_types_pkg::fn_nor, cpu_types_pkg::fn_sll,
              cpu_types_pkg::fn_srl, cpu_types_pkg::fn_slt, cpu_types_pkg::fn_sltu};
      for (int i = 0; i < rand_words; i++) begin
         kind = rand_bits(4);
         rs   = 5'(rand_bits(4));   // r0..r15 only
         rt   = 5'(rand_bits(4));
         rd   = 5'(rand_bits(4));
         imm  = 16'(rand_bits(16));
         if (kind < 5) begin
            fn = fns[4'(rand_bits(4) % 12)];
            sh = (fn == cpu_types_pkg::fn_sll || fn == cpu_types_pkg::fn_srl) ?
                 5'(rand_bits(5)) : 5'd0;
            imem[i] = {cpu_types_pkg::rtype, rs, rt, rd, sh, fn};
         end else begin
            case (kind)
               5, 14:   op = cpu_types_pkg::ori;
               6:       op = cpu_types_pkg::andi;
               7:       op = cpu_types_pkg::xori;
               8, 15:   op = cpu_types_pkg::lui;
               9, 10:   op = cpu_types_pkg::lw;
               11:      op = cpu_types_pkg::sw;
               12:      op = cpu_types_pkg::beq;
               default: op = cpu_types_pkg::bne;
            endcase
            if (op == cpu_types_pkg::lw || op == cpu_types_pkg::sw) begin
               rs  = 5'd0;   // base r0, word inside the scratch area
               imm = 16'((rand_bits(6) % 48) * 4);
            end
            if (op == cpu_types_pkg::beq || op == cpu_types_pkg::bne) begin
               off = int'(rand_bits(2));
               if (off > rand_words - 1 - i) off = rand_words - 1 - i;   // stay before the dump
               imm = 16'(off);
            end
            imem[i] = {op, rs, rt, imm};
         end
      end
      for (int k = 1; k < 16; k++) begin
         imem[rand_words - 1 + k] = {cpu_types_pkg::sw, 5'd0, 5'(k), 16'((rand_words - 1 + k) * 4)};
      end
      imem[63] = {cpu_types_pkg::halt, 26'd0};
   endtask

   // compare the port with the model, then commit in the model
   task automatic check_cycle();
      logic [31:0] iw;
      iw = imem[m_pc[7:2]];
      check_word("pc", m_pc, imem_addr);
      model_step(iw);
      check_word("store strobe", 32'(exp_wen), 32'(dmem_wen));
      check_word("load strobe", 32'(exp_ren), 32'(dmem_ren));
      if (exp_wen) begin
         check_word("store addr", exp_addr, dmem_addr);
         check_word("store data", exp_wdata, dmem_wdata);
         if (iw[20:16] == 5'd0) check_word("r0 store", 32'h0, dmem_wdata);
      end
   endtask

   initial begin
      clk    = 1'b0;
      rst   <= 1'b1;
      errors = 0;
      lfsr   = 16'd3;
      for (int i = 0; i < 64; i++) begin
         dmem[i] <= '0;
      end
      build_program();
      model_reset();
      saved_word = imem[0];
      imem[0]    = {cpu_types_pkg::lw, 5'd0, 5'd1, 16'd0};   // strobes must stay low in reset
      repeat (6) @(posedge clk);
      @(negedge clk);
      check_word("reset pc", 32'h0, imem_addr);
      check_word("reset halted", 32'h0, 32'(halted));
      check_word("reset ren", 32'h0, 32'(dmem_ren));
      @(posedge clk);
      imem[0] <= {cpu_types_pkg::sw, 5'd0, 5'd1, 16'd0};
      @(negedge clk);
      check_word("reset wen", 32'h0, 32'(dmem_wen));
      @(posedge clk);
      imem[0] <= saved_word;   // back to the generated program
      rst     <= 1'b0;
      cycles = 0;
      while (!halted && cycles < timeout_cycles) begin
         @(negedge clk);
         if (!halted) check_cycle();
         cycles++;
      end
      if (!halted) begin
         errors++;
         $display("Timeout: halted did not rise within %0d cycles", timeout_cycles);
      end else begin
         check_word("model halted", 32'd1, 32'(m_halted));
         hold_addr = imem_addr;
         check_word("halt pc", m_pc, hold_addr);
         @(posedge clk);
         // a store under the parked pc, the halted core must ignore it
         imem[hold_addr[7:2]] <= {cpu_types_pkg::sw, 5'd0, 5'd1, 16'd0};
         repeat (10) begin
            @(negedge clk);
            check_word("halted after halt", 32'h1, 32'(halted));
            check_word("pc after halt", hold_addr, imem_addr);
            check_word("wen after halt", 32'h0, 32'(dmem_wen));
         end
      end
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verif
source/cpu_types_pkg.sv
source/alu.sv
source/register_file.sv
source/control_unit.sv
source/single_cycle_cpu.sv
verif/cpu_tb.sv

// File: Makefile
RTL = source/cpu_types_pkg.sv source/alu.sv source/register_file.sv \
      source/control_unit.sv source/single_cycle_cpu.sv

all: run

run:
	verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb | tee sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --top-module single_cycle_cpu $(RTL)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
